// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// quad word address is the byte address without its low four bits
	localparam int QW_ADDR_BITS = 28;
	localparam int WORDS_PER_QW = 4;

	// control register bit positions
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_FLUSH_BIT = 1;

	// four instructions, word 0 sits in the lowest 32 bits
	typedef logic [WORDS_PER_QW-1:0][31:0] qword_t;

	// fetch unit to cache
	typedef struct packed {
		logic valid;
		logic [QW_ADDR_BITS-1:0] addr;
	} cache_req_t;

	// cache to fetch unit
	// rvalid and addr/rdata hold until the next accepted request
	typedef struct packed {
		logic ready;
		logic rvalid;
		logic [QW_ADDR_BITS-1:0] addr;
		qword_t rdata;
	} cache_rsp_t;

	// idle: nothing on the read bus yet
	// lookup: read bus holds a result, new lookups are taken
	// refill_wait: miss sent to memory, waiting for the line
	typedef enum logic [1:0] {
		IC_IDLE,
		IC_LOOKUP,
		IC_REFILL_WAIT
	} icache_state_t;

	typedef enum logic [1:0] {
		CSR_BOOT_VECTOR = 2'd0,
		CSR_CONTROL = 2'd1,
		CSR_RESTART = 2'd2
	} csr_addr_t;

endpackage

`default_nettype wire

// File: verilog/fetch_csr.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_csr #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input logic clk,
	input logic i_reset,

	// configuration write port, one write per strobe
	input logic i_cfg_we,
	input fetch_pkg::csr_addr_t i_cfg_addr,
	input logic [31:0] i_cfg_wdata,

	// to fetch unit
	output logic [31:0] o_boot_vector,
	output logic o_restart,

	// to instruction cache
	output logic o_cache_enable,
	output logic o_flush
);

	import fetch_pkg::*;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_boot_vector <= RESET_VECTOR;
			// cache comes up enabled
			o_cache_enable <= 1'b1;
			o_flush <= 1'b0;
			o_restart <= 1'b0;
		end else begin
			// strobes last a single cycle
			o_flush <= 1'b0;
			o_restart <= 1'b0;
			if (i_cfg_we) begin
				case (i_cfg_addr)
					CSR_BOOT_VECTOR: begin
						o_boot_vector <= i_cfg_wdata;
					end
					CSR_CONTROL: begin
						o_cache_enable <= i_cfg_wdata[CTRL_ENABLE_BIT];
						// flush bit is self clearing
						o_flush <= i_cfg_wdata[CTRL_FLUSH_BIT];
					end
					CSR_RESTART: begin
						// any write here restarts, data ignored
						o_restart <= 1'b1;
					end
					default: begin
						// unmapped address, write dropped
						o_restart <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/icache_dm.sv
`timescale 1ns/1ps
`default_nettype none

module icache_dm #(
	parameter int CACHE_LINES = 16
) (
	input logic clk,
	input logic i_reset,

	// fetch side
	input fetch_pkg::cache_req_t i_req,
	output fetch_pkg::cache_rsp_t o_rsp,

	// configuration
	input logic i_enable,
	input logic i_flush,

	// refill side, one miss outstanding
	output logic o_mem_req,
	output logic [fetch_pkg::QW_ADDR_BITS-1:0] o_mem_addr,
	input logic i_mem_rvalid,
	input fetch_pkg::qword_t i_mem_rdata
);

	import fetch_pkg::*;

	localparam int IDX_BITS = $clog2(CACHE_LINES);
	localparam int TAG_BITS = QW_ADDR_BITS - IDX_BITS;

	// line storage
	logic [TAG_BITS-1:0] tag_mem [CACHE_LINES];
	qword_t data_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0] line_valid;

	icache_state_t state;

	// held read result
	logic [QW_ADDR_BITS-1:0] rsp_addr;
	qword_t rsp_data;

	// miss address, also drives the memory port
	logic [QW_ADDR_BITS-1:0] miss_addr;

	logic [IDX_BITS-1:0] req_idx;
	logic [TAG_BITS-1:0] req_tag;
	logic [IDX_BITS-1:0] fill_idx;
	logic [TAG_BITS-1:0] fill_tag;
	logic accept;
	logic hit;
	logic fill;

	always_comb begin
		req_idx = i_req.addr[IDX_BITS-1:0];
		req_tag = i_req.addr[QW_ADDR_BITS-1:IDX_BITS];
		fill_idx = miss_addr[IDX_BITS-1:0];
		fill_tag = miss_addr[QW_ADDR_BITS-1:IDX_BITS];

		// lookups are refused only while a refill is in flight
		o_rsp.ready = (state != IC_REFILL_WAIT);
		o_rsp.rvalid = (state == IC_LOOKUP);
		o_rsp.addr = rsp_addr;
		o_rsp.rdata = rsp_data;

		accept = i_req.valid & o_rsp.ready;
		// a disabled cache misses on everything
		hit = i_enable & line_valid[req_idx] & (tag_mem[req_idx] == req_tag);
		fill = (state == IC_REFILL_WAIT) & i_mem_rvalid;
	end

	assign o_mem_addr = miss_addr;

	// controller
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= IC_IDLE;
			o_mem_req <= 1'b0;
			line_valid <= '0;
		end else begin
			o_mem_req <= 1'b0;
			case (state)
				IC_IDLE, IC_LOOKUP: begin
					if (accept) begin
						if (hit) begin
							state <= IC_LOOKUP;
						end else begin
							// one cycle pulse toward memory
							state <= IC_REFILL_WAIT;
							o_mem_req <= 1'b1;
						end
					end
				end
				IC_REFILL_WAIT: begin
					// latency is up to the memory
					if (i_mem_rvalid) begin
						state <= IC_LOOKUP;
					end
				end
				default: begin
					state <= IC_IDLE;
				end
			endcase

			// flush wins over a fill landing in the same cycle
			if (i_flush) begin
				line_valid <= '0;
			end else if (fill && i_enable) begin
				line_valid[fill_idx] <= 1'b1;
			end
		end
	end

	// arrays and read result
	always_ff @(posedge clk) begin
		if (accept && !hit) begin
			miss_addr <= i_req.addr;
		end
		if (accept && hit) begin
			rsp_addr <= i_req.addr;
			rsp_data <= data_mem[req_idx];
		end else if (fill) begin
			// refill data goes straight to the read bus
			rsp_addr <= miss_addr;
			rsp_data <= i_mem_rdata;
			// allocate only while enabled
			if (i_enable) begin
				tag_mem[fill_idx] <= fill_tag;
				data_mem[fill_idx] <= i_mem_rdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input logic clk,
	input logic i_reset,

	// pipeline side
	input logic i_pipeline_ready,
	input logic i_redirect,
	input logic [31:0] i_redirect_pc,

	// configuration
	input logic [31:0] i_boot_vector,
	input logic i_restart,

	// cache side
	output fetch_pkg::cache_req_t o_cache_req,
	input fetch_pkg::cache_rsp_t i_cache_rsp,

	// registered pipeline outputs
	output logic o_valid,
	output logic [31:0] o_pc,
	output logic [31:0] o_instruction
);

	import fetch_pkg::*;

	// byte offset bits inside a quad word
	localparam int OFS_BITS = 32 - QW_ADDR_BITS;

	// program counter of the next instruction to show
	logic [31:0] pc;
	// first cycle after reset fetches from the boot vector
	logic boot_pending;

	logic start;
	logic discard;
	logic [31:0] fetch_pc;
	logic [31:0] seq_pc;
	logic on_bus;
	logic last_word;
	logic load;

	always_comb begin
		start = boot_pending | i_restart;
		// current item is dropped on restart or redirect
		discard = start | i_redirect;

		if (start) begin
			fetch_pc = i_boot_vector;
		end else if (i_redirect) begin
			fetch_pc = i_redirect_pc;
		end else begin
			fetch_pc = pc;
		end
		seq_pc = fetch_pc + 32'd4;

		// instruction already sitting on the cache read bus?
		on_bus = i_cache_rsp.rvalid && (i_cache_rsp.addr == fetch_pc[31:OFS_BITS]);
		last_word = &fetch_pc[OFS_BITS-1:2];

		// output register may take a new item
		// held under back-pressure unless discarded
		load = ~o_valid | i_pipeline_ready | discard;

		o_cache_req.valid = 1'b0;
		o_cache_req.addr = fetch_pc[31:OFS_BITS];
		if (load) begin
			if (!on_bus) begin
				// block missing from the read bus, go get it
				o_cache_req.valid = 1'b1;
			end else if (last_word) begin
				// last word is being captured into the output register,
				// so the read bus is free for the next block already
				o_cache_req.valid = 1'b1;
				o_cache_req.addr = seq_pc[31:OFS_BITS];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			boot_pending <= 1'b1;
			pc <= i_boot_vector;
			o_valid <= 1'b0;
		end else begin
			boot_pending <= 1'b0;
			if (load) begin
				o_valid <= on_bus;
				// advance only past an instruction actually shown
				pc <= on_bus ? seq_pc : fetch_pc;
			end
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (load && on_bus) begin
			o_pc <= fetch_pc;
			o_instruction <= i_cache_rsp.rdata[fetch_pc[OFS_BITS-1:2]];
		end
	end

endmodule

`default_nettype wire

// File: verilog/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
	parameter int CACHE_LINES = 16
) (
	input logic clk,
	input logic i_reset,

	// configuration writes
	input logic i_cfg_we,
	input fetch_pkg::csr_addr_t i_cfg_addr,
	input logic [31:0] i_cfg_wdata,

	// pipeline
	input logic i_pipeline_ready,
	input logic i_redirect,
	input logic [31:0] i_redirect_pc,
	output logic o_valid,
	output logic [31:0] o_pc,
	output logic [31:0] o_instruction,

	// memory refill port
	output logic o_mem_req,
	output logic [fetch_pkg::QW_ADDR_BITS-1:0] o_mem_addr,
	input logic i_mem_rvalid,
	input fetch_pkg::qword_t i_mem_rdata
);

	import fetch_pkg::*;

	// configuration outputs
	logic [31:0] boot_vector;
	logic restart;
	logic cache_enable;
	logic flush;

	// fetch to cache
	cache_req_t cache_req;
	cache_rsp_t cache_rsp;

	fetch_csr #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch_csr_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_cfg_we(i_cfg_we),
		.i_cfg_addr(i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata),
		.o_boot_vector(boot_vector),
		.o_restart(restart),
		.o_cache_enable(cache_enable),
		.o_flush(flush)
	);

	fetch_unit fetch_unit_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_pipeline_ready(i_pipeline_ready),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_boot_vector(boot_vector),
		.i_restart(restart),
		.o_cache_req(cache_req),
		.i_cache_rsp(cache_rsp),
		.o_valid(o_valid),
		.o_pc(o_pc),
		.o_instruction(o_instruction)
	);

	icache_dm #(
		.CACHE_LINES(CACHE_LINES)
	) icache_dm_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_req(cache_req),
		.o_rsp(cache_rsp),
		.i_enable(cache_enable),
		.i_flush(flush),
		.o_mem_req(o_mem_req),
		.o_mem_addr(o_mem_addr),
		.i_mem_rvalid(i_mem_rvalid),
		.i_mem_rdata(i_mem_rdata)
	);

endmodule

`default_nettype wire

// File: verification/ifetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_checker (
	input logic clk,
	input logic i_reset,
	input logic i_pipeline_ready,
	input logic i_redirect,
	input logic i_restart,
	input logic i_valid,
	input logic [31:0] i_pc,
	input logic [31:0] i_instruction,
	input logic i_mem_req
);

	// memory image holds each word's own byte address under this key
	localparam logic [31:0] INSTR_KEY = 32'hA5A5_0000;

	// failed assertions so far, one count per property
	int instr_fails = 0;
	int reset_fails = 0;
	int hold_fails = 0;
	int failures;

	assign failures = instr_fails + reset_fails + hold_fails;

	// a shown instruction follows from its pc
	instr_matches_pc: assert property (@(posedge clk) disable iff (i_reset)
		i_valid |-> (i_instruction == (i_pc ^ INSTR_KEY)))
		else begin
			$error("instruction %h does not belong to pc %h", i_instruction, i_pc);
			instr_fails++;
		end

	// registers come out of reset quiet
	quiet_in_reset: assert property (@(posedge clk) i_reset |=> (!i_mem_req && !i_valid))
		else begin
			$error("memory request or valid item while in reset");
			reset_fails++;
		end

	// stalled item stays put unless thrown away
	hold_when_stalled: assert property (@(posedge clk) disable iff (i_reset)
		(i_valid && !i_pipeline_ready && !i_redirect && !i_restart)
		|=> (i_valid && $stable(i_pc) && $stable(i_instruction)))
		else begin
			$error("stalled item changed at pc %h", i_pc);
			hold_fails++;
		end

endmodule

bind ifetch_top ifetch_checker ifetch_checker_inst (
	.clk(clk),
	.i_reset(i_reset),
	.i_pipeline_ready(i_pipeline_ready),
	.i_redirect(i_redirect),
	.i_restart(restart),
	.i_valid(o_valid),
	.i_pc(o_pc),
	.i_instruction(o_instruction),
	.i_mem_req(o_mem_req)
);

`default_nettype wire

// File: verification/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

	import fetch_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int CACHE_LINES = 16;
	localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
	localparam logic [31:0] LOOP_BASE = 32'h0000_4000;
	// maps onto the loop's cache lines with other tags
	localparam logic [31:0] ALIAS_BASE = LOOP_BASE + 32'(CACHE_LINES * 16);
	localparam logic [31:0] INSTR_KEY = 32'hA5A5_0000;
	// a pass covers four quad words
	// the block after them is fetched early on the last word
	localparam int LOOP_ITEMS = 16;
	localparam int LOOP_REQUESTS = LOOP_ITEMS / 4 + 1;
	// cycle budgets of one take_items call
	localparam int BUDGET_LONG = 300;
	localparam int BUDGET_SHORT = 150;
	// two long calls in tests 1 and 2, twelve short ones after
	localparam int WATCHDOG_CYCLES = 2 * (2 * BUDGET_LONG + 12 * BUDGET_SHORT);

	logic clk;
	logic i_reset;
	logic i_cfg_we;
	csr_addr_t i_cfg_addr;
	logic [31:0] i_cfg_wdata;
	logic i_pipeline_ready;
	logic i_redirect;
	logic [31:0] i_redirect_pc;
	logic o_valid;
	logic [31:0] o_pc;
	logic [31:0] o_instruction;
	logic o_mem_req;
	logic [QW_ADDR_BITS-1:0] o_mem_addr;
	logic i_mem_rvalid;
	qword_t i_mem_rdata;

	int errors;
	int checks;
	int errors_before;
	int mem_requests;
	logic [31:0] expected_pc;

	ifetch_top #(
		.RESET_VECTOR(RESET_VECTOR),
		.CACHE_LINES(CACHE_LINES)
	) ifetch_top_inst (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// refill memory, one miss at a time, 1 to 6 cycles late
	initial begin
		int delay;
		logic [QW_ADDR_BITS-1:0] addr;
		mem_requests = 0;
		i_mem_rvalid = 1'b0;
		i_mem_rdata = '0;
		forever begin
			@(negedge clk);
			i_mem_rvalid = 1'b0;
			if (o_mem_req) begin
				mem_requests++;
				addr = o_mem_addr;
				delay = int'($urandom_range(6, 1));
				repeat (delay - 1) @(negedge clk);
				// word k holds its byte address xor the key
				for (int k = 0; k < 4; k++) begin
					i_mem_rdata[k] = ({addr, 4'b0000} + 32'(4 * k)) ^ INSTR_KEY;
				end
				i_mem_rvalid = 1'b1;
			end
		end
	end

	// own checks plus failed assertions of the bound checker
	function automatic int error_count();
		return errors + ifetch_top_inst.ifetch_checker_inst.failures;
	endfunction

	// accept count items while stalling stall_pct percent of the cycles
	task automatic take_items(input int count, input int stall_pct, input int budget);
		int taken;
		int cycles;
		logic held;
		logic [31:0] held_pc;
		logic [31:0] held_instr;
		taken = 0;
		cycles = 0;
		held = 1'b0;
		held_pc = '0;
		held_instr = '0;
		while (taken < count && cycles < budget) begin
			@(negedge clk);
			cycles++;
			// item stalled last cycle must be unchanged
			if (held) begin
				checks++;
				assert (o_valid && o_pc == held_pc && o_instruction == held_instr) else begin
					$display("mismatch at %0t: stalled item at pc %h changed", $time, held_pc);
					errors++;
				end
			end
			i_pipeline_ready = (int'($urandom_range(99, 0)) >= stall_pct);
			held = o_valid && !i_pipeline_ready;
			held_pc = o_pc;
			held_instr = o_instruction;
			// accepted on the coming rising edge
			if (o_valid && i_pipeline_ready) begin
				checks++;
				assert (o_pc == expected_pc && o_instruction == (expected_pc ^ INSTR_KEY)) else begin
					$display("mismatch at %0t: pc %h instr %h, expected pc %h instr %h",
						$time, o_pc, o_instruction, expected_pc, expected_pc ^ INSTR_KEY);
					errors++;
				end
				expected_pc = expected_pc + 32'd4;
				taken++;
			end
		end
		if (taken < count) begin
			$display("at %0t only %0d of %0d items arrived within %0d cycles",
				$time, taken, count, budget);
			errors++;
		end
	endtask

	task automatic redirect_to(input logic [31:0] target);
		@(negedge clk);
		i_pipeline_ready = 1'b0;
		i_redirect = 1'b1;
		i_redirect_pc = target;
		@(negedge clk);
		i_redirect = 1'b0;
		expected_pc = target;
	endtask

	task automatic write_csr(input csr_addr_t addr, input logic [31:0] data);
		@(negedge clk);
		i_pipeline_ready = 1'b0;
		i_cfg_we = 1'b1;
		i_cfg_addr = addr;
		i_cfg_wdata = data;
		@(negedge clk);
		i_cfg_we = 1'b0;
		// flush and restart strobes land one cycle after the write
		@(negedge clk);
	endtask

	// one pass over the loop at base, entered by redirect
	// a negative expected count only warms the cache
	task automatic loop_pass(input logic [31:0] base, input int expected_requests);
		int start_count;
		@(negedge clk);
		i_pipeline_ready = 1'b0;
		repeat (2) @(negedge clk);
		start_count = mem_requests;
		redirect_to(base);
		take_items(LOOP_ITEMS, 0, BUDGET_SHORT);
		@(negedge clk);
		i_pipeline_ready = 1'b0;
		// early fetch of the next block has been counted by now
		repeat (2) @(negedge clk);
		if (expected_requests >= 0) begin
			checks++;
			assert (mem_requests - start_count == expected_requests) else begin
				$display("mismatch at %0t: loop pass made %0d memory requests, expected %0d",
					$time, mem_requests - start_count, expected_requests);
				errors++;
			end
		end
	endtask

	task automatic report_test(input int num, input string name);
		int total;
		total = error_count();
		if (total == errors_before) begin
			$display("test %0d %s ok", num, name);
		end else begin
			$display("test %0d %s failed with %0d errors", num, name, total - errors_before);
		end
		errors_before = total;
	endtask

	initial begin
		logic [31:0] target;
		void'($urandom(40));
		clk = 1'b0;
		i_reset = 1'b1;
		i_cfg_we = 1'b0;
		i_cfg_addr = CSR_BOOT_VECTOR;
		i_cfg_wdata = '0;
		i_pipeline_ready = 1'b0;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		errors = 0;
		checks = 0;
		errors_before = 0;
		expected_pc = RESET_VECTOR;
		repeat (8) @(negedge clk);
		i_reset = 1'b0;

		take_items(24, 0, BUDGET_LONG);
		report_test(1, "sequential fetch from reset vector");
		take_items(24, 40, BUDGET_LONG);
		report_test(2, "pipeline back-pressure");

		// first pass misses, second hits, disabled passes miss again
		loop_pass(LOOP_BASE, LOOP_REQUESTS);
		loop_pass(LOOP_BASE, 0);
		write_csr(CSR_CONTROL, 32'h0);
		loop_pass(LOOP_BASE, LOOP_REQUESTS);
		// an allocating refill here would evict the loop's lines
		loop_pass(ALIAS_BASE, LOOP_REQUESTS);
		// disabled refills allocated nothing so the loop still hits
		write_csr(CSR_CONTROL, 32'h1);
		loop_pass(LOOP_BASE, 0);
		report_test(3, "loop reuse and cache disable");

		for (int n = 0; n < 3; n++) begin
			target = 32'h0010_0000 | ($urandom & 32'h000F_FFFC);
			redirect_to(target);
			take_items(6, 20, BUDGET_SHORT);
		end
		report_test(4, "redirect");

		target = 32'h0002_0000 | ($urandom & 32'h0000_FFFC);
		write_csr(CSR_BOOT_VECTOR, target);
		write_csr(CSR_RESTART, 32'h0);
		expected_pc = target;
		take_items(12, 20, BUDGET_SHORT);
		report_test(5, "boot vector and restart");

		// enable bit stays set while the flush bit clears all lines
		loop_pass(LOOP_BASE, -1);
		loop_pass(LOOP_BASE, 0);
		write_csr(CSR_CONTROL, 32'h3);
		loop_pass(LOOP_BASE, LOOP_REQUESTS);
		report_test(6, "flush");

		$display("checks %0d, errors %0d", checks, error_count());
		if (error_count() == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
verilog/fetch_pkg.sv
verilog/fetch_csr.sv
verilog/icache_dm.sv
verilog/fetch_unit.sv
verilog/ifetch_top.sv
verification/ifetch_checker.sv
verification/ifetch_tb.sv

// File: Makefile
SIM      := verilator
TOP      := ifetch_tb
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS := +verilator+error+limit+1000
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, pass if the log holds the pass line"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
